// File: Bender.yml
package:
  name: load_store_queue

sources:
  - files:
      - lsq_types_pkg.sv
      - lsq_instr_pkg.sv
      - lsq_entry_table.sv
      - lsq_translate.sv
      - lsq_store_buffer.sv
      - lsq_issue_select.sv
      - load_store_queue.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_load_store_queue.sv

// File: filelist.f
+incdir+.
lsq_types_pkg.sv
lsq_instr_pkg.sv
lsq_entry_table.sv
lsq_translate.sv
lsq_store_buffer.sv
lsq_issue_select.sv
load_store_queue.sv
tb_load_store_queue.sv

// File: load_store_queue.sv
/* Load/store queue top: entry table, dTLB translation, issue select
   and commit-gated store buffer */
`timescale 1ns/1ps

module load_store_queue #(
    parameter int LsqEntries = lsq_types_pkg::LSQ_ENTRIES_DEFAULT,
    parameter int SbEntries  = lsq_types_pkg::SB_ENTRIES_DEFAULT
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,
    // Rename side
    input  logic                      instr_valid_i,
    input  lsq_instr_pkg::mem_instr_t instr_i,
    output logic                      instr_ready_o,
    // dTLB
    output logic                      tlb_req_valid_o,
    output lsq_instr_pkg::tlb_req_t   tlb_req_o,
    input  logic                      tlb_resp_valid_i,
    input  lsq_instr_pkg::tlb_resp_t  tlb_resp_i,
    // Cache side
    output logic                      out_valid_o,
    output lsq_instr_pkg::mem_instr_t out_o,
    input  logic                      out_ready_i,
    // Commit
    input  logic                      commit_valid_i,
    input  lsq_types_pkg::gl_index_t  commit_tag_i,
    output logic                      load_blocked_o,
    output logic                      empty_o
);

    logic                      table_full;
    logic                      push;
    logic                      has_head;
    logic                      has_xlate;
    lsq_instr_pkg::mem_instr_t head_entry;
    lsq_instr_pkg::mem_instr_t xlate_entry;
    logic                      xlate_update;
    lsq_instr_pkg::mem_instr_t xlate_result;
    logic                      head_pop;
    logic                      sb_push;
    logic                      sb_pop;
    logic                      sb_full;
    logic                      sb_empty;
    logic                      sb_release_valid;
    lsq_instr_pkg::mem_instr_t sb_release_entry;
    logic                      sb_collision;

    assign instr_ready_o = ~table_full & ~flush_i;
    assign push          = instr_valid_i & instr_ready_o;

    lsq_entry_table #(
        .LsqEntries(LsqEntries)
    ) entry_table0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .flush_i       (flush_i),
        .push_i        (push),
        .push_entry_i  (instr_i),
        .xlate_update_i(xlate_update),
        .xlate_entry_i (xlate_result),
        .head_pop_i    (head_pop),
        .full_o        (table_full),
        .has_head_o    (has_head),
        .head_entry_o  (head_entry),
        .has_xlate_o   (has_xlate),
        .xlate_entry_o (xlate_entry)
    );

    lsq_translate translate0 (
        .has_xlate_i     (has_xlate),
        .xlate_entry_i   (xlate_entry),
        .tlb_resp_valid_i(tlb_resp_valid_i),
        .tlb_resp_i      (tlb_resp_i),
        .tlb_req_valid_o (tlb_req_valid_o),
        .tlb_req_o       (tlb_req_o),
        .update_o        (xlate_update),
        .entry_o         (xlate_result)
    );

    lsq_store_buffer #(
        .SbEntries(SbEntries)
    ) store_buffer0 (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .flush_i        (flush_i),
        .push_i         (sb_push),
        .push_entry_i   (head_entry),
        .commit_valid_i (commit_valid_i),
        .commit_tag_i   (commit_tag_i),
        .pop_i          (sb_pop),
        .load_addr_i    (head_entry.addr),   // Physical once at the head
        .full_o         (sb_full),
        .empty_o        (sb_empty),
        .release_valid_o(sb_release_valid),
        .release_entry_o(sb_release_entry),
        .collision_o    (sb_collision)
    );

    lsq_issue_select issue_select0 (
        .has_head_i        (has_head),
        .head_entry_i      (head_entry),
        .sb_full_i         (sb_full),
        .sb_release_valid_i(sb_release_valid),
        .sb_release_entry_i(sb_release_entry),
        .collision_i       (sb_collision),
        .out_ready_i       (out_ready_i),
        .out_valid_o       (out_valid_o),
        .out_o             (out_o),
        .head_pop_o        (head_pop),
        .sb_push_o         (sb_push),
        .sb_pop_o          (sb_pop),
        .load_blocked_o    (load_blocked_o)
    );

    // Nothing waiting in any stage
    assign empty_o = ~has_head & ~has_xlate & sb_empty;

endmodule

// File: lsq_entry_table.sv
/* Circular table of memory instructions with tail, translate and head
   pointers and per-stage occupancy counters */
`timescale 1ns/1ps

module lsq_entry_table #(
    parameter int LsqEntries = lsq_types_pkg::LSQ_ENTRIES_DEFAULT
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,
    input  logic                      push_i,
    input  lsq_instr_pkg::mem_instr_t push_entry_i,
    input  logic                      xlate_update_i,
    input  lsq_instr_pkg::mem_instr_t xlate_entry_i,
    input  logic                      head_pop_i,
    output logic                      full_o,
    output logic                      has_head_o,
    output lsq_instr_pkg::mem_instr_t head_entry_o,
    output logic                      has_xlate_o,
    output lsq_instr_pkg::mem_instr_t xlate_entry_o
);

    localparam int PtrW = $clog2(LsqEntries);
    localparam int CntW = PtrW + 1;   // Must hold LsqEntries itself

    typedef logic [PtrW-1:0] ptr_t;
    typedef logic [CntW-1:0] cnt_t;

    lsq_instr_pkg::mem_instr_t table_q [LsqEntries];
    lsq_instr_pkg::mem_instr_t push_wr;

    ptr_t tail_q;    // Next free slot
    ptr_t xlate_q;   // Oldest untranslated entry
    ptr_t head_q;    // Oldest translated entry

    cnt_t num_xlate_q;   // Written, waiting for the dTLB
    cnt_t num_issue_q;   // Translated, waiting to leave
    cnt_t num_total;

    // Wraps for sizes that are not a power of two
    function automatic ptr_t ptr_inc(ptr_t ptr);
        ptr_t nxt;
        if (ptr == ptr_t'(LsqEntries - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    // Incoming entries always start untranslated and clean
    always_comb begin
        push_wr            = push_entry_i;
        push_wr.translated = 1'b0;
        push_wr.xcpt_valid = 1'b0;
        push_wr.xcpt_cause = '0;
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            table_q[tail_q] <= push_wr;
        end
        if (xlate_update_i) begin
            table_q[xlate_q] <= xlate_entry_i;   // Written back in place
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            tail_q      <= '0;
            xlate_q     <= '0;
            head_q      <= '0;
            num_xlate_q <= '0;
            num_issue_q <= '0;
        end else if (flush_i) begin
            tail_q      <= '0;
            xlate_q     <= '0;
            head_q      <= '0;
            num_xlate_q <= '0;
            num_issue_q <= '0;
        end else begin
            if (push_i) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (xlate_update_i) begin
                xlate_q <= ptr_inc(xlate_q);
            end
            if (head_pop_i) begin
                head_q <= ptr_inc(head_q);
            end
            num_xlate_q <= num_xlate_q + cnt_t'(push_i) - cnt_t'(xlate_update_i);
            num_issue_q <= num_issue_q + cnt_t'(xlate_update_i) - cnt_t'(head_pop_i);
        end
    end

    assign num_total = num_xlate_q + num_issue_q;
    assign full_o    = (num_total == cnt_t'(LsqEntries));

    // Head only ever walks over translated entries
    assign has_head_o   = (num_issue_q != '0);
    assign head_entry_o = table_q[head_q];

    assign has_xlate_o   = (num_xlate_q != '0);
    assign xlate_entry_o = table_q[xlate_q];

endmodule

// File: lsq_instr_pkg.sv
/* Memory op and size encodings, exception causes, and the instruction
   and dTLB request/response structs */
package lsq_instr_pkg;

    typedef logic [1:0] mem_op_t;

    localparam mem_op_t MEM_LOAD  = 2'd0;
    localparam mem_op_t MEM_STORE = 2'd1;
    localparam mem_op_t MEM_AMO   = 2'd2;   // Handled like a store

    // log2 of the access size in bytes
    typedef logic [1:0] mem_size_t;

    typedef logic [3:0] xcpt_cause_t;

    // RISC-V exception codes
    localparam xcpt_cause_t LD_MISALIGNED = 4'd4;
    localparam xcpt_cause_t ST_MISALIGNED = 4'd6;
    localparam xcpt_cause_t LD_PAGE_FAULT = 4'd13;
    localparam xcpt_cause_t ST_PAGE_FAULT = 4'd15;

    typedef struct packed {
        lsq_types_pkg::gl_index_t gl_index;
        mem_op_t                  mem_op;
        mem_size_t                mem_size;
        lsq_types_pkg::addr_t     addr;         // Virtual until translated
        lsq_types_pkg::data_t     data;
        logic                     translated;
        logic                     xcpt_valid;
        xcpt_cause_t              xcpt_cause;
    } mem_instr_t;

    typedef struct packed {
        lsq_types_pkg::vpn_t vpn;
        logic                store;
    } tlb_req_t;

    typedef struct packed {
        lsq_types_pkg::ppn_t ppn;
        logic                page_fault;
    } tlb_resp_t;

    // Stores and AMOs share the store path and cause codes
    function automatic logic is_store_op(mem_op_t op);
        return (op == MEM_STORE) || (op == MEM_AMO);
    endfunction

endpackage

// File: lsq_issue_select.sv
/* Per-cycle choice between store buffer release, head issue to the cache
   and hand-off of a clean head store to the store buffer */
`timescale 1ns/1ps

module lsq_issue_select (
    input  logic                      has_head_i,
    input  lsq_instr_pkg::mem_instr_t head_entry_i,
    input  logic                      sb_full_i,
    input  logic                      sb_release_valid_i,
    input  lsq_instr_pkg::mem_instr_t sb_release_entry_i,
    input  logic                      collision_i,
    input  logic                      out_ready_i,
    output logic                      out_valid_o,
    output lsq_instr_pkg::mem_instr_t out_o,
    output logic                      head_pop_o,
    output logic                      sb_push_o,
    output logic                      sb_pop_o,
    output logic                      load_blocked_o
);

    logic head_is_store;
    logic head_direct;   // Goes straight to the cache
    logic head_ready;
    logic head_issue;

    assign head_is_store = lsq_instr_pkg::is_store_op(head_entry_i.mem_op);

    // Loads and excepted entries of any kind take the direct path
    assign head_direct = has_head_i & (~head_is_store | head_entry_i.xcpt_valid);
    assign head_ready  = head_direct & ~collision_i;

    assign load_blocked_o = head_direct & ~head_is_store & collision_i;

    // Committed store release wins the output
    assign out_valid_o = sb_release_valid_i | head_ready;
    assign out_o       = sb_release_valid_i ? sb_release_entry_i : head_entry_i;

    assign sb_pop_o   = sb_release_valid_i & out_ready_i;
    assign head_issue = ~sb_release_valid_i & head_ready & out_ready_i;

    // Clean stores wait for commit inside the buffer
    assign sb_push_o = has_head_i & head_is_store & ~head_entry_i.xcpt_valid & ~sb_full_i;

    assign head_pop_o = head_issue | sb_push_o;

endmodule

// File: lsq_stim.txt
// op size vaddr gl_index data group (hex)
// op 0 load, 1 store, 2 AMO; size is log2 of the access bytes
0 3 0000001008 01 0 1
0 2 0000002004 02 0 1
0 0 0000003001 03 0 1
0 3 0000001004 04 0 2
1 1 0000002001 05 123 2
2 2 0000003002 06 0 2
0 3 0100001000 07 0 3
1 2 0100002000 08 55 3
0 2 0100003002 09 0 3
1 3 0000004000 0a 1111 4
1 3 0000004008 0b 2222 4
2 3 0000004010 0c 3333 4
1 3 0000005010 0d abcd 5
0 2 0000006000 0e 0 5
0 2 0000005014 0f 0 5
0 3 0000007000 10 0 6
0 3 0000007008 11 0 6
0 3 0000007010 12 0 6
0 3 0000007018 13 0 6
0 3 0000007020 14 0 6
0 3 0000007028 15 0 6
0 3 0000007030 16 0 6
0 3 0000007038 17 0 6
0 3 0000007040 18 0 6

// File: lsq_store_buffer.sv
/* In-order buffer of translated stores, released by commit of the head,
   with 8-byte word collision check for the head load */
`timescale 1ns/1ps

module lsq_store_buffer #(
    parameter int SbEntries = lsq_types_pkg::SB_ENTRIES_DEFAULT
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,
    input  logic                      push_i,
    input  lsq_instr_pkg::mem_instr_t push_entry_i,
    input  logic                      commit_valid_i,
    input  lsq_types_pkg::gl_index_t  commit_tag_i,
    input  logic                      pop_i,
    input  lsq_types_pkg::addr_t      load_addr_i,
    output logic                      full_o,
    output logic                      empty_o,
    output logic                      release_valid_o,
    output lsq_instr_pkg::mem_instr_t release_entry_o,
    output logic                      collision_o
);

    localparam int PtrW  = $clog2(SbEntries);
    localparam int AddrW = lsq_types_pkg::ADDR_W;
    localparam int WordW = lsq_types_pkg::WORD_OFFSET_W;

    typedef logic [PtrW-1:0] ptr_t;

    lsq_instr_pkg::mem_instr_t sb_q [SbEntries];
    logic [SbEntries-1:0]      valid_q;
    ptr_t                      head_q;
    ptr_t                      tail_q;
    ptr_t                      head_nxt;
    logic                      committed_q;   // Head store acked by commit
    logic                      commit_hit;

    function automatic ptr_t ptr_inc(ptr_t ptr);
        ptr_t nxt;
        if (ptr == ptr_t'(SbEntries - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign head_nxt = ptr_inc(head_q);

    // On a pop the tag is checked against the store that becomes head
    always_comb begin
        if (pop_i) begin
            commit_hit = commit_valid_i && valid_q[head_nxt]
                         && (sb_q[head_nxt].gl_index == commit_tag_i);
        end else begin
            commit_hit = commit_valid_i && valid_q[head_q]
                         && (sb_q[head_q].gl_index == commit_tag_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            sb_q[tail_q] <= push_entry_i;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q     <= '0;
            head_q      <= '0;
            tail_q      <= '0;
            committed_q <= 1'b0;
        end else if (flush_i) begin
            valid_q     <= '0;
            head_q      <= '0;
            tail_q      <= '0;
            committed_q <= 1'b0;
        end else begin
            if (pop_i) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_nxt;
            end
            if (push_i) begin
                valid_q[tail_q] <= 1'b1;   // Different slot from the popped one
                tail_q          <= ptr_inc(tail_q);
            end
            committed_q <= commit_hit | (committed_q & ~pop_i);
        end
    end

    assign full_o  = &valid_q;
    assign empty_o = ~|valid_q;

    assign release_valid_o = committed_q;
    assign release_entry_o = sb_q[head_q];

    // Any buffered store in the same physical 8-byte word
    always_comb begin
        collision_o = 1'b0;
        for (int i = 0; i < SbEntries; i++) begin
            if (valid_q[i] && (sb_q[i].addr[AddrW-1:WordW] == load_addr_i[AddrW-1:WordW])) begin
                collision_o = 1'b1;
            end
        end
    end

endmodule

// File: lsq_translate.sv
/* dTLB request for the oldest untranslated entry, physical address merge
   and misaligned / page-fault exception check */
`timescale 1ns/1ps

module lsq_translate (
    input  logic                      has_xlate_i,
    input  lsq_instr_pkg::mem_instr_t xlate_entry_i,
    input  logic                      tlb_resp_valid_i,
    input  lsq_instr_pkg::tlb_resp_t  tlb_resp_i,
    output logic                      tlb_req_valid_o,
    output lsq_instr_pkg::tlb_req_t   tlb_req_o,
    output logic                      update_o,
    output lsq_instr_pkg::mem_instr_t entry_o
);

    localparam int AddrW = lsq_types_pkg::ADDR_W;
    localparam int OffW  = lsq_types_pkg::PAGE_OFFSET_W;

    logic       is_store;
    logic [2:0] align_mask;
    logic       misaligned;

    assign is_store = lsq_instr_pkg::is_store_op(xlate_entry_i.mem_op);

    // Request stays stable as long as the entry waits
    assign tlb_req_valid_o = has_xlate_i;
    assign tlb_req_o.vpn   = xlate_entry_i.addr[AddrW-1:OffW];
    assign tlb_req_o.store = is_store;

    assign update_o = has_xlate_i & tlb_resp_valid_i;

    // Low address bits that must be zero for the access size
    always_comb begin
        case (xlate_entry_i.mem_size)
            2'd0:    align_mask = 3'b000;
            2'd1:    align_mask = 3'b001;
            2'd2:    align_mask = 3'b011;
            default: align_mask = 3'b111;
        endcase
    end

    assign misaligned = |(xlate_entry_i.addr[2:0] & align_mask);

    always_comb begin
        entry_o            = xlate_entry_i;
        entry_o.translated = 1'b1;
        entry_o.xcpt_valid = 1'b0;
        entry_o.xcpt_cause = '0;

        if (misaligned) begin   // Checked before the page fault
            entry_o.xcpt_valid = 1'b1;
            entry_o.xcpt_cause = is_store ? lsq_instr_pkg::ST_MISALIGNED
                                          : lsq_instr_pkg::LD_MISALIGNED;
        end else if (tlb_resp_i.page_fault) begin
            entry_o.xcpt_valid = 1'b1;
            entry_o.xcpt_cause = is_store ? lsq_instr_pkg::ST_PAGE_FAULT
                                          : lsq_instr_pkg::LD_PAGE_FAULT;
        end

        // Faulting entries keep the virtual address as the bad address
        if (!entry_o.xcpt_valid) begin
            entry_o.addr = {tlb_resp_i.ppn, xlate_entry_i.addr[OffW-1:0]};
        end
    end

endmodule

// File: lsq_types_pkg.sv
/* Address, page number, commit tag and data widths with their vector types,
   plus the default queue and store buffer sizes */
package lsq_types_pkg;

    // Address layout
    localparam int ADDR_W        = 40;
    localparam int PAGE_OFFSET_W = 12;
    localparam int PN_W          = ADDR_W - PAGE_OFFSET_W;   // 28-bit page numbers

    // Low bits ignored when matching 8-byte words
    localparam int WORD_OFFSET_W = 3;

    localparam int GL_INDEX_W = 5;
    localparam int DATA_W     = 64;

    // Virtual or physical byte address
    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [PN_W-1:0] vpn_t;
    typedef logic [PN_W-1:0] ppn_t;

    // Global index from rename, doubles as commit tag
    typedef logic [GL_INDEX_W-1:0] gl_index_t;

    typedef logic [DATA_W-1:0] data_t;

    // Default sizes
    localparam int LSQ_ENTRIES_DEFAULT = 8;
    localparam int SB_ENTRIES_DEFAULT  = 4;

endpackage

// File: tb_lsq_checks.svh
/* LFSR step, typed compare tasks and the stimulus file reader */
`ifndef TB_LSQ_CHECKS_SVH
`define TB_LSQ_CHECKS_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
endfunction

task automatic check_instr(input string name, input lsq_instr_pkg::mem_instr_t got,
                           input lsq_instr_pkg::mem_instr_t exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        errors++;
    end
endtask

// Six hex words per line, unused slots stay all ones
task automatic read_stim();
    for (int i = 0; i < STIM_WORDS; i++) begin
        stim_words[i] = '1;
    end
    $readmemh("lsq_stim.txt", stim_words);
    n_lines = 0;
    while (n_lines < MAX_LINES && stim_words[6*n_lines] != '1) begin
        n_lines++;
    end
endtask

`endif

// File: tb_load_store_queue.sv
/* Testbench for the load/store queue: clock, reset, DUT, dTLB model,
   commit driver, output scoreboard and watchdog */
`timescale 1ns/1ps

module tb_load_store_queue;

    localparam int MAX_LINES  = 32;
    localparam int STIM_WORDS = 6 * MAX_LINES;

    logic clk_i;
    logic rstn_i;
    logic flush_i;
    logic instr_valid_i;
    lsq_instr_pkg::mem_instr_t instr_i;
    logic instr_ready_o;
    logic tlb_req_valid_o;
    lsq_instr_pkg::tlb_req_t tlb_req_o;
    logic tlb_resp_valid_i;
    lsq_instr_pkg::tlb_resp_t tlb_resp_i;
    logic out_valid_o;
    lsq_instr_pkg::mem_instr_t out_o;
    logic out_ready_i;
    logic commit_valid_i;
    lsq_types_pkg::gl_index_t commit_tag_i;
    logic load_blocked_o;
    logic empty_o;

    logic [63:0] stim_words [STIM_WORDS];
    int          n_lines;
    int          errors;
    logic        stim_loaded;
    logic [15:0] lfsr;
    int          blocked_cycles;
    int          passed_loads;   // Loads that left ahead of an older store

    lsq_instr_pkg::mem_instr_t exp_direct[$];   // Loads and excepted entries
    lsq_instr_pkg::mem_instr_t exp_store[$];    // Clean stores awaiting commit
    logic exp_req_store[$];                     // Store flag per entry awaiting the dTLB
    logic [31:0] commit_sent;
    logic [31:0] out_seen;

    `include "tb_lsq_checks.svh"

    load_store_queue dut0 (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .flush_i         (flush_i),
        .instr_valid_i   (instr_valid_i),
        .instr_i         (instr_i),
        .instr_ready_o   (instr_ready_o),
        .tlb_req_valid_o (tlb_req_valid_o),
        .tlb_req_o       (tlb_req_o),
        .tlb_resp_valid_i(tlb_resp_valid_i),
        .tlb_resp_i      (tlb_resp_i),
        .out_valid_o     (out_valid_o),
        .out_o           (out_o),
        .out_ready_i     (out_ready_i),
        .commit_valid_i  (commit_valid_i),
        .commit_tag_i    (commit_tag_i),
        .load_blocked_o  (load_blocked_o),
        .empty_o         (empty_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // Instruction as rename hands it over
    function automatic lsq_instr_pkg::mem_instr_t line_instr(int n);
        lsq_instr_pkg::mem_instr_t m;
        m          = '0;
        m.mem_op   = stim_words[6*n][1:0];
        m.mem_size = stim_words[6*n+1][1:0];
        m.addr     = stim_words[6*n+2][39:0];
        m.gl_index = stim_words[6*n+3][4:0];
        m.data     = stim_words[6*n+4];
        return m;
    endfunction

    // Misaligned wins over a fault on VPN bit 20 and a clean access maps to VPN + 0x100
    function automatic lsq_instr_pkg::mem_instr_t expect_result(lsq_instr_pkg::mem_instr_t m);
        lsq_instr_pkg::mem_instr_t e;
        logic st;
        int bytes;
        e = m;
        st = (m.mem_op != lsq_instr_pkg::MEM_LOAD);
        bytes = 1 << m.mem_size;
        e.translated = 1'b1;
        if (m.addr % bytes != 0) begin
            e.xcpt_valid = 1'b1;
            e.xcpt_cause = st ? 4'd6 : 4'd4;
        end else if (m.addr[32]) begin
            e.xcpt_valid = 1'b1;
            e.xcpt_cause = st ? 4'd15 : 4'd13;
        end else begin
            e.addr[39:12] = m.addr[39:12] + 28'h100;
        end
        return e;
    endfunction

    // dTLB model with one LFSR bit per cycle deciding a stall
    always @(negedge clk_i) begin
        lfsr             = lfsr_step(lfsr);
        tlb_resp_valid_i = tlb_req_valid_o & ~lfsr[0];
        tlb_resp_i.ppn   = tlb_req_o.vpn + 28'h100;
        tlb_resp_i.page_fault = tlb_req_o.vpn[20];
    end

    always @(posedge clk_i) begin
        if (rstn_i && load_blocked_o) blocked_cycles++;
        if (rstn_i && out_valid_o && out_ready_i) check_output(out_o);
        if (rstn_i && tlb_req_valid_o && tlb_resp_valid_i) begin
            if (exp_req_store.size() == 0) begin
                $display("dTLB request with no instruction waiting for translation");
                errors++;
            end else begin
                check_bit("tlb_req_o.store", tlb_req_o.store, exp_req_store.pop_front());
            end
        end
    end

    task automatic check_output(input lsq_instr_pkg::mem_instr_t got);
        lsq_instr_pkg::mem_instr_t e;
        if (got.mem_op != lsq_instr_pkg::MEM_LOAD && !got.xcpt_valid) begin
            if (exp_store.size() == 0) begin
                $display("Unexpected store on the cache port, tag %h", got.gl_index);
                errors++;
            end else begin
                e = exp_store.pop_front();
                check_bit("commit_sent", commit_sent[got.gl_index], 1'b1);
                check_instr("out_o", got, e);
                out_seen[got.gl_index] = 1'b1;
            end
        end else if (exp_direct.size() == 0) begin
            $display("Unexpected load or exception on the cache port, tag %h", got.gl_index);
            errors++;
        end else begin
            e = exp_direct.pop_front();
            foreach (exp_store[i]) begin
                if (got.mem_op == lsq_instr_pkg::MEM_LOAD && !got.xcpt_valid
                    && exp_store[i].gl_index < got.gl_index) begin
                    if (exp_store[i].addr[39:3] == got.addr[39:3]) begin
                        $display("Load %h left before an older store to the same word",
                                 got.gl_index);
                        errors++;
                    end else begin
                        passed_loads++;
                    end
                end
            end
            check_instr("out_o", got, e);
        end
    endtask

    task automatic push_lines(input int first, input int last);
        lsq_instr_pkg::mem_instr_t m;
        for (int n = first; n <= last; n++) begin
            m = line_instr(n);
            @(negedge clk_i);
            instr_valid_i = 1'b1;
            instr_i       = m;
            do @(posedge clk_i); while (!instr_ready_o);
            exp_req_store.push_back(m.mem_op != lsq_instr_pkg::MEM_LOAD);
            if (m.mem_op != lsq_instr_pkg::MEM_LOAD && !expect_result(m).xcpt_valid) begin
                exp_store.push_back(expect_result(m));
            end else begin
                exp_direct.push_back(expect_result(m));
            end
        end
        @(negedge clk_i);
        instr_valid_i = 1'b0;
    endtask

    // Stores committed in program order. A pulse is held back while a load can
    // still overtake the store, and repeated until the store leaves
    task automatic drive_commits(input int first, input int last);
        lsq_instr_pkg::mem_instr_t m;
        for (int n = first; n <= last; n++) begin
            m = line_instr(n);
            if (m.mem_op != lsq_instr_pkg::MEM_LOAD && !expect_result(m).xcpt_valid) begin
                while (!out_seen[m.gl_index]) begin
                    repeat (3) @(negedge clk_i);
                    while (exp_direct.size() != 0 && !load_blocked_o) @(negedge clk_i);
                    if (!out_seen[m.gl_index]) begin
                        commit_valid_i = 1'b1;
                        commit_tag_i   = m.gl_index;
                        commit_sent[m.gl_index] = 1'b1;
                        @(negedge clk_i);
                        commit_valid_i = 1'b0;
                    end
                end
            end
        end
    endtask

    // Back-pressure fill followed by a flush
    task automatic fill_and_flush(input int first, input int last);
        lsq_instr_pkg::mem_instr_t m;
        int accepted;
        accepted = 0;
        out_ready_i = 1'b0;
        for (int n = first; n <= last; n++) begin
            m = line_instr(n);
            @(negedge clk_i);
            instr_valid_i = 1'b1;
            instr_i       = m;
            @(posedge clk_i);
            if (instr_ready_o) begin
                accepted++;
                exp_req_store.push_back(m.mem_op != lsq_instr_pkg::MEM_LOAD);
            end
        end
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        if (accepted != 8) begin
            $display("Table accepted %0d entries instead of 8", accepted);
            errors++;
        end
        check_bit("instr_ready_o", instr_ready_o, 1'b0);
        repeat (10) @(negedge clk_i);
        check_bit("out_valid_o", out_valid_o, 1'b1);
        check_instr("out_o", out_o, expect_result(line_instr(first)));
        repeat (5) @(negedge clk_i);
        check_bit("out_valid_o", out_valid_o, 1'b1);
        check_instr("out_o", out_o, expect_result(line_instr(first)));
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        exp_req_store.delete();
        repeat (4) begin
            check_bit("empty_o", empty_o, 1'b1);
            check_bit("out_valid_o", out_valid_o, 1'b0);
            @(negedge clk_i);
        end
        out_ready_i = 1'b1;
    endtask

    initial begin
        int first;
        int last;
        int grp;
        int tests;
        int failed;
        int err_before;
        rstn_i = 1'b0;
        flush_i = 1'b0;
        instr_valid_i = 1'b0;
        instr_i = '0;
        tlb_resp_valid_i = 1'b0;
        tlb_resp_i = '0;
        out_ready_i = 1'b1;
        commit_valid_i = 1'b0;
        commit_tag_i = '0;
        lfsr = 16'd21;
        errors = 0;
        tests = 0;
        failed = 0;
        blocked_cycles = 0;
        passed_loads = 0;
        stim_loaded = 1'b0;
        read_stim();
        stim_loaded = 1'b1;
        repeat (10) @(negedge clk_i);
        rstn_i = 1'b1;
        check_bit("instr_ready_o", instr_ready_o, 1'b1);
        check_bit("empty_o", empty_o, 1'b1);
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("tlb_req_valid_o", tlb_req_valid_o, 1'b0);
        check_bit("load_blocked_o", load_blocked_o, 1'b0);
        first = 0;
        while (first < n_lines) begin
            grp = stim_words[6*first+5];
            last = first;
            while (last + 1 < n_lines && stim_words[6*(last+1)+5] == grp) last++;
            err_before = errors;
            commit_sent = '0;
            out_seen = '0;
            blocked_cycles = 0;
            passed_loads = 0;
            if (grp == 6) begin
                fill_and_flush(first, last);
            end else begin
                fork
                    push_lines(first, last);
                    drive_commits(first, last);
                join
                while (exp_direct.size() != 0 || exp_store.size() != 0) @(negedge clk_i);
                @(negedge clk_i);
                check_bit("empty_o", empty_o, 1'b1);
            end
            if (grp == 5) begin
                if (blocked_cycles == 0) begin
                    $display("load_blocked_o never rose for the colliding load");
                    errors++;
                end
                if (passed_loads == 0) begin
                    $display("The load to another word did not pass the buffered store");
                    errors++;
                end
            end else if (blocked_cycles != 0) begin
                $display("load_blocked_o rose in a group without a colliding load");
                errors++;
            end
            tests++;
            if (errors != err_before) failed++;
            $display("Test %0d (group %0d): %s, %0d blocked cycles", tests, grp,
                     (errors == err_before) ? "ok" : "errors", blocked_cycles);
            first = last + 1;
        end
        $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog scaled by the stimulus length
    initial begin
        wait (stim_loaded);
        repeat (10 + 200 * n_lines) @(posedge clk_i);
        $display("Timeout, the run did not finish in %0d cycles", 200 * n_lines);
        $display("Simulation FAILED");
        $finish;
    end

endmodule
